// File: glb_ring.f
+incdir+design
design/global_buffer_pkg.sv
design/glb_ifs.sv
design/glb_tile_router.sv
design/glb_tile_core.sv
design/glb_tile.sv
design/glb_ring.sv
dv/glb_ring_checker.sv
dv/glb_ring_tb.sv

// File: Makefile
# Verilator flow for the global buffer ring

VERILATOR ?= verilator
TOP       ?= glb_ring_tb
FILELIST  ?= glb_ring.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST PASS" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/glb_ring_tb.sv
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_ring_tb
    import global_buffer_pkg::*;
();

    localparam int NT = `GLB_NUM_TILES;
    localparam int NADDR = 1 << (`GLB_TILE_SEL_WIDTH + `GLB_BANK_ADDR_WIDTH);
    localparam int RAND_LEN = 60;
    localparam logic [1:0] OP_IDLE = 2'd0;
    localparam logic [1:0] OP_WR = 2'd1;
    localparam logic [1:0] OP_RD = 2'd2;

    // one table row
    // exp only meaningful when has_exp is set
    typedef struct {
        logic [1:0] op;
        glb_addr_t  addr;
        glb_data_t  data;
        logic       has_exp;
        glb_data_t  exp;
    } entry_t;

    logic      clk;
    logic      reset;
    logic      host_wr_en;
    glb_addr_t host_wr_addr;
    glb_data_t host_wr_data;
    logic      host_rd_en;
    glb_addr_t host_rd_addr;
    logic      host_rd_valid;
    glb_data_t host_rd_data;

    entry_t    stim[$];
    // reference copy of all banks
    glb_data_t ref_mem [NADDR];
    // expected word and due cycle of each outstanding read
    glb_data_t exp_q[$];
    int        due_q[$];
    int        cyc = 0;
    int        seed = 1145;
    bit        table_ready = 0;

    glb_ring glb_ring_inst (
        .clk          (clk),
        .reset        (reset),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr),
        .host_rd_valid(host_rd_valid),
        .host_rd_data (host_rd_data)
    );

    always #20 clk = ~clk;

    // rising edges seen so far
    always @(posedge clk) cyc <= cyc + 1;

    task automatic stop_run(input string reason);
        $display("%s at %0t", reason, $time);
        $display("TEST FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
            stop_run("value mismatch");
        end
    endtask

    function automatic glb_addr_t make_addr(input int tile, input int word);
        return {tile_sel_t'(tile), bank_addr_t'(word)};
    endfunction

    function automatic glb_data_t word_for(input int tile, input int salt);
        return glb_data_t'(((tile + 1) * 257) ^ salt);
    endfunction

    task automatic add_entry(input logic [1:0] op, input glb_addr_t addr, input glb_data_t data,
                             input logic has_exp, input glb_data_t exp);
        entry_t e;
        e.op = op;
        e.addr = addr;
        e.data = data;
        e.has_exp = has_exp;
        e.exp = exp;
        stim.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] d;
        // every word reads zero before any write
        for (int a = 0; a < NADDR; a++) begin
            add_entry(OP_RD, glb_addr_t'(a), '0, 1'b1, '0);
        end
        // one word per tile
        for (int t = 0; t < NT; t++) begin
            add_entry(OP_WR, make_addr(t, 5), word_for(t, 16'h5a00), 1'b0, '0);
        end
        add_entry(OP_IDLE, '0, '0, 1'b0, '0);
        add_entry(OP_IDLE, '0, '0, 1'b0, '0);
        // read back later with reads back to back
        for (int t = NT - 1; t >= 0; t--) begin
            add_entry(OP_RD, make_addr(t, 5), '0, 1'b1, word_for(t, 16'h5a00));
        end
        // read right behind the write of the same word
        for (int t = 0; t < NT; t++) begin
            add_entry(OP_WR, make_addr(t, 9), word_for(t, 16'h0c3c), 1'b0, '0);
            add_entry(OP_RD, make_addr(t, 9), '0, 1'b1, word_for(t, 16'h0c3c));
        end
        // random tail on a few words per tile so reads hit written data
        for (int i = 0; i < RAND_LEN; i++) begin
            r = $random(seed);
            d = $random(seed);
            add_entry((r[1:0] == 2'd3) ? OP_RD : r[1:0],
                      make_addr(int'(r[15:8]) % NT, int'(r[17:16])),
                      glb_data_t'(d), 1'b0, '0);
        end
        table_ready = 1;
    endtask

    // drive one row and update the model at issue time
    task automatic drive_entry(input entry_t e);
        host_wr_en = (e.op == OP_WR);
        host_wr_addr = (e.op == OP_WR) ? e.addr : '0;
        host_wr_data = (e.op == OP_WR) ? e.data : '0;
        host_rd_en = (e.op == OP_RD);
        host_rd_addr = (e.op == OP_RD) ? e.addr : '0;
        if (e.op == OP_WR) begin
            ref_mem[e.addr] = e.data;
        end else if (e.op == OP_RD) begin
            if (e.has_exp) begin
                check_value("expected read value", 32'(ref_mem[e.addr]), 32'(e.exp));
            end
            exp_q.push_back(ref_mem[e.addr]);
            due_q.push_back(cyc + NT);
        end
    endtask

    // responses sampled mid cycle where they are settled
    always @(negedge clk) begin
        if (!reset) begin
            if (host_rd_valid) begin
                if (exp_q.size() == 0) begin
                    stop_run("response arrived with no read outstanding");
                end else begin
                    check_value("host_rd_valid cycle", cyc, due_q[0]);
                    check_value("host_rd_data", 32'(host_rd_data), 32'(exp_q[0]));
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
                stop_run("read response missing");
            end
        end
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((stim.size() + NT + 20) * 40);
        stop_run("timeout, the run did not finish in time");
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk = 0;
        reset = 1;
        host_wr_en = 0;
        host_wr_addr = '0;
        host_wr_data = '0;
        host_rd_en = 0;
        host_rd_addr = '0;
        foreach (ref_mem[a]) begin
            ref_mem[a] = '0;
        end
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 0;
        foreach (stim[i]) begin
            @(negedge clk);
            drive_entry(stim[i]);
        end
        @(negedge clk);
        drive_entry('{OP_IDLE, '0, '0, 1'b0, '0});
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // watch a full round trip for stray responses
        repeat (NT + 2) @(negedge clk);
        if (glb_ring_inst.checker_inst.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("assertion failures in the checker: %0d",
                     glb_ring_inst.checker_inst.fail_count);
            stop_run("checker assertion failed");
        end
    end

endmodule

// File: dv/glb_ring_checker.sv
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_ring_checker
    import global_buffer_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      host_rd_en,
    input logic      host_rd_valid,
    input glb_data_t host_rd_data
);

    // counts failed assertions, read back by the testbench at the end
    int unsigned fail_count = 0;

    // no response while the ring is held in reset
    a_quiet_in_reset: assert property (@(posedge clk) reset |-> !host_rd_valid)
        else begin
            fail_count = fail_count + 1;
            $error("host_rd_valid high during reset");
        end

    // first edge after release is still quiet
    a_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !host_rd_valid)
        else begin
            fail_count = fail_count + 1;
            $error("host_rd_valid high just after reset");
        end

    // fixed round trip, one hop per tile
    a_latency: assert property (@(posedge clk) disable iff (reset)
        host_rd_valid == $past(host_rd_en, `GLB_NUM_TILES))
        else begin
            fail_count = fail_count + 1;
            $error("host_rd_valid does not follow host_rd_en by the ring latency");
        end

    // valid data is fully known
    a_known_data: assert property (@(posedge clk) disable iff (reset)
        host_rd_valid |-> !$isunknown(host_rd_data))
        else begin
            fail_count = fail_count + 1;
            $error("host_rd_data unknown while valid");
        end

endmodule

bind glb_ring glb_ring_checker checker_inst (
    .clk          (clk),
    .reset        (reset),
    .host_rd_en   (host_rd_en),
    .host_rd_valid(host_rd_valid),
    .host_rd_data (host_rd_data)
);

// File: design/glb_ring.sv
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_ring
    import global_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      host_wr_en,
    input  glb_addr_t host_wr_addr,
    input  glb_data_t host_wr_data,
    input  logic      host_rd_en,
    input  glb_addr_t host_rd_addr,
    output logic      host_rd_valid,
    output glb_data_t host_rd_data
);

    localparam int NT = `GLB_NUM_TILES;

    glb_host_if host_if ();

    // links between neighbours
    glb_ring_if link [NT-1] ();
    // idle edges, the start and end routers turn packets before these
    glb_ring_if edge_west ();
    glb_ring_if edge_east ();

    assign host_if.host_wr_en   = host_wr_en;
    assign host_if.host_wr_addr = host_wr_addr;
    assign host_if.host_wr_data = host_wr_data;
    assign host_if.host_rd_en   = host_rd_en;
    assign host_if.host_rd_addr = host_rd_addr;
    assign host_rd_valid        = host_if.host_rd_valid;
    assign host_rd_data         = host_if.host_rd_data;

    // nothing enters from beyond the ends
    assign edge_west.wr_lr   = '0;
    assign edge_west.rdrq_lr = '0;
    assign edge_west.rdrs_lr = '0;
    assign edge_east.wr_rl   = '0;
    assign edge_east.rdrq_rl = '0;
    assign edge_east.rdrs_rl = '0;

    // chain of tiles, tile 0 faces the host
    generate
        for (genvar i = 0; i < NT; i++) begin : g_tile
            if (i == 0) begin : g_first
                glb_tile #(.TILE_ID(i)) tile_inst (
                    .clk(clk), .reset(reset),
                    .west(edge_west), .east(link[0]), .host(host_if)
                );
            end else if (i == NT - 1) begin : g_last
                glb_tile #(.TILE_ID(i)) tile_inst (
                    .clk(clk), .reset(reset),
                    .west(link[i-1]), .east(edge_east), .host(host_if)
                );
            end else begin : g_mid
                glb_tile #(.TILE_ID(i)) tile_inst (
                    .clk(clk), .reset(reset),
                    .west(link[i-1]), .east(link[i]), .host(host_if)
                );
            end
        end
    endgenerate

endmodule

// File: design/glb_tile.sv
`timescale 1ns/1ps

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input logic            clk,
    input logic            reset,
    glb_ring_if.east_tile  west,
    glb_ring_if.west_tile  east,
    glb_host_if.start_core host
);

    // router to core link
    glb_core_if core_if ();

    // ring side, turnaround and parity routing
    glb_tile_router #(
        .TILE_ID(TILE_ID)
    ) router_inst (
        .clk  (clk),
        .reset(reset),
        .west (west),
        .east (east),
        .core (core_if.router)
    );

    // bank side, host only matters on tile 0
    glb_tile_core #(
        .TILE_ID(TILE_ID)
    ) core_inst (
        .clk  (clk),
        .reset(reset),
        .rtr  (core_if.core),
        .host (host)
    );

endmodule

// File: design/glb_tile_core.sv
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_tile_core
    import global_buffer_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input logic            clk,
    input logic            reset,
    glb_core_if.core       rtr,
    glb_host_if.start_core host
);

    localparam int BANK_DEPTH = 1 << `GLB_BANK_ADDR_WIDTH;
    localparam tile_sel_t MY_SEL = tile_sel_t'(TILE_ID);

    // one bank of words
    glb_data_t bank [BANK_DEPTH];

    // address split of arriving packets
    tile_sel_t  wr_sel;
    tile_sel_t  rd_sel;
    bank_addr_t wr_bank_addr;
    bank_addr_t rd_bank_addr;

    // ownership of arriving packets
    logic wr_hit;
    logic rd_hit;

    // response built from our own bank
    rdrs_packet_t own_rdrs;

    assign wr_sel       = rtr.wr_r2c.wr_addr[`GLB_BANK_ADDR_WIDTH +: `GLB_TILE_SEL_WIDTH];
    assign wr_bank_addr = rtr.wr_r2c.wr_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign rd_sel       = rtr.rdrq_r2c.rd_addr[`GLB_BANK_ADDR_WIDTH +: `GLB_TILE_SEL_WIDTH];
    assign rd_bank_addr = rtr.rdrq_r2c.rd_addr[`GLB_BANK_ADDR_WIDTH-1:0];

    assign wr_hit = rtr.wr_r2c.wr_en && (wr_sel == MY_SEL);
    assign rd_hit = rtr.rdrq_r2c.rd_en && (rd_sel == MY_SEL);

    // bank write at the edge, cleared on reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                bank[i] <= '0;
            end
        end else if (wr_hit) begin
            bank[wr_bank_addr] <= rtr.wr_r2c.wr_data;
        end
    end

    // async read, answer in the same cycle the request lands
    assign own_rdrs.rd_data_valid = rd_hit;
    assign own_rdrs.rd_data = rd_hit ? bank[rd_bank_addr] : '0;

    generate
        if (TILE_ID == 0) begin : g_start
            // every packet ends its trip here, so the slot is free for the host
            assign rtr.wr_c2r.wr_en     = host.host_wr_en;
            assign rtr.wr_c2r.wr_addr   = host.host_wr_addr;
            assign rtr.wr_c2r.wr_data   = host.host_wr_data;
            assign rtr.rdrq_c2r.rd_en   = host.host_rd_en;
            assign rtr.rdrq_c2r.rd_addr = host.host_rd_addr;
            // a new slot never carries a response
            assign rtr.rdrs_c2r = '0;

            // returning response or a read of our own bank, never both
            assign host.host_rd_valid = own_rdrs.rd_data_valid |
                                        rtr.rdrs_r2c.rd_data_valid;
            assign host.host_rd_data = own_rdrs.rd_data_valid ? own_rdrs.rd_data
                                                              : rtr.rdrs_r2c.rd_data;
        end else begin : g_relay
            // owned packets stop here, others go on unchanged
            assign rtr.wr_c2r   = wr_hit ? '0 : rtr.wr_r2c;
            assign rtr.rdrq_c2r = rd_hit ? '0 : rtr.rdrq_r2c;
            // the response takes over the request's slot
            assign rtr.rdrs_c2r = rd_hit ? own_rdrs : rtr.rdrs_r2c;
        end
    endgenerate

endmodule

// File: design/glb_tile_router.sv
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_tile_router
    import global_buffer_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input logic           clk,
    input logic           reset,
    glb_ring_if.east_tile west,
    glb_ring_if.west_tile east,
    glb_core_if.router    core
);

    // position flags, all constant per tile
    localparam bit IS_START = (TILE_ID == 0);
    localparam bit IS_END = (TILE_ID == `GLB_NUM_TILES - 1);
    // even tiles take eastward traffic, odd tiles westward
    localparam bit IS_EVEN = ((TILE_ID % 2) == 0);

    // inputs after turnaround
    wr_packet_t   wr_w_in;
    wr_packet_t   wr_e_in;
    rdrq_packet_t rdrq_w_in;
    rdrq_packet_t rdrq_e_in;
    rdrs_packet_t rdrs_w_in;
    rdrs_packet_t rdrs_e_in;
    // outputs before leaving the tile
    wr_packet_t   wr_e_out;
    wr_packet_t   wr_w_out;
    rdrq_packet_t rdrq_e_out;
    rdrq_packet_t rdrq_w_out;
    rdrs_packet_t rdrs_e_out;
    rdrs_packet_t rdrs_w_out;
    // core to router stage
    wr_packet_t   wr_d1;
    rdrq_packet_t rdrq_d1;
    rdrs_packet_t rdrs_d1;

    // start tile folds westward output back east
    assign wr_w_in   = IS_START ? wr_w_out : west.wr_lr;
    assign rdrq_w_in = IS_START ? rdrq_w_out : west.rdrq_lr;
    assign rdrs_w_in = IS_START ? rdrs_w_out : west.rdrs_lr;
    // end tile folds eastward output back west
    assign wr_e_in   = IS_END ? wr_e_out : east.wr_rl;
    assign rdrq_e_in = IS_END ? rdrq_e_out : east.rdrq_rl;
    assign rdrs_e_in = IS_END ? rdrs_e_out : east.rdrs_rl;

    // one hop per tile, this is the only register on the path
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_d1   <= '0;
            rdrq_d1 <= '0;
            rdrs_d1 <= '0;
        end else begin
            wr_d1   <= core.wr_c2r;
            rdrq_d1 <= core.rdrq_c2r;
            rdrs_d1 <= core.rdrs_c2r;
        end
    end

    // deliver the track this tile owns
    assign core.wr_r2c   = IS_EVEN ? wr_w_in : wr_e_in;
    assign core.rdrq_r2c = IS_EVEN ? rdrq_w_in : rdrq_e_in;
    assign core.rdrs_r2c = IS_EVEN ? rdrs_w_in : rdrs_e_in;

    // eastward, inject on even tiles, pass through on odd
    assign wr_e_out   = IS_EVEN ? wr_d1 : wr_w_in;
    assign rdrq_e_out = IS_EVEN ? rdrq_d1 : rdrq_w_in;
    assign rdrs_e_out = IS_EVEN ? rdrs_d1 : rdrs_w_in;
    // westward, the other way round
    assign wr_w_out   = IS_EVEN ? wr_e_in : wr_d1;
    assign rdrq_w_out = IS_EVEN ? rdrq_e_in : rdrq_d1;
    assign rdrs_w_out = IS_EVEN ? rdrs_e_in : rdrs_d1;

    assign east.wr_lr   = wr_e_out;
    assign east.rdrq_lr = rdrq_e_out;
    assign east.rdrs_lr = rdrs_e_out;
    assign west.wr_rl   = wr_w_out;
    assign west.rdrq_rl = rdrq_w_out;
    assign west.rdrs_rl = rdrs_w_out;

endmodule

// File: design/glb_ifs.sv
`timescale 1ns/1ps

// link between tile i (west) and tile i+1 (east)
interface glb_ring_if import global_buffer_pkg::*; ();
    // eastward track, driven by the west tile
    wr_packet_t   wr_lr;
    rdrq_packet_t rdrq_lr;
    rdrs_packet_t rdrs_lr;
    // westward track, driven by the east tile
    wr_packet_t   wr_rl;
    rdrq_packet_t rdrq_rl;
    rdrs_packet_t rdrs_rl;

    modport west_tile (output wr_lr, rdrq_lr, rdrs_lr, input wr_rl, rdrq_rl, rdrs_rl);
    modport east_tile (input wr_lr, rdrq_lr, rdrs_lr, output wr_rl, rdrq_rl, rdrs_rl);
endinterface

// router to core link inside one tile
interface glb_core_if import global_buffer_pkg::*; ();
    // core to router, registered in the router
    wr_packet_t   wr_c2r;
    rdrq_packet_t rdrq_c2r;
    rdrs_packet_t rdrs_c2r;
    // router to core, same cycle
    wr_packet_t   wr_r2c;
    rdrq_packet_t rdrq_r2c;
    rdrs_packet_t rdrs_r2c;

    modport router (input wr_c2r, rdrq_c2r, rdrs_c2r, output wr_r2c, rdrq_r2c, rdrs_r2c);
    modport core (output wr_c2r, rdrq_c2r, rdrs_c2r, input wr_r2c, rdrq_r2c, rdrs_r2c);
endinterface

// host port, only the start core uses it
interface glb_host_if import global_buffer_pkg::*; ();
    logic      host_wr_en;
    glb_addr_t host_wr_addr;
    glb_data_t host_wr_data;
    logic      host_rd_en;
    glb_addr_t host_rd_addr;
    logic      host_rd_valid;
    glb_data_t host_rd_data;

    modport host (
        output host_wr_en, host_wr_addr, host_wr_data, host_rd_en, host_rd_addr,
        input  host_rd_valid, host_rd_data
    );
    modport start_core (
        input  host_wr_en, host_wr_addr, host_wr_data, host_rd_en, host_rd_addr,
        output host_rd_valid, host_rd_data
    );
endinterface

// File: design/global_buffer_pkg.sv
`include "glb_macros.svh"

package global_buffer_pkg;

    // tile select, upper part of a global address
    typedef logic [`GLB_TILE_SEL_WIDTH-1:0] tile_sel_t;
    // word address inside one bank
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;
    // global address, tile select above bank address
    typedef logic [`GLB_TILE_SEL_WIDTH+`GLB_BANK_ADDR_WIDTH-1:0] glb_addr_t;
    typedef logic [`GLB_DATA_WIDTH-1:0] glb_data_t;

    // write packet
    typedef struct packed {
        logic      wr_en;
        glb_addr_t wr_addr;
        glb_data_t wr_data;
    } wr_packet_t;

    // read request packet
    typedef struct packed {
        logic      rd_en;
        glb_addr_t rd_addr;
    } rdrq_packet_t;

    // read response packet
    typedef struct packed {
        logic      rd_data_valid;
        glb_data_t rd_data;
    } rdrs_packet_t;

endpackage

// File: design/glb_macros.svh
`ifndef GLB_MACROS_SVH
`define GLB_MACROS_SVH

// number of tiles on the ring, must be even and at least 2
`define GLB_NUM_TILES 4
// log2 of the tile count
`define GLB_TILE_SEL_WIDTH 2

// word address width inside one bank
`define GLB_BANK_ADDR_WIDTH 4
// one data word
`define GLB_DATA_WIDTH 16

`endif
